//--- flist.f
vcore_profiler_pkg.sv
event_decoder.sv
load_scoreboard.sv
stat_counter_bank.sv
apb_stat_port.sv
vcore_profiler.sv
tb_vcore_profiler_assert.sv
tb_vcore_profiler.sv

//--- Makefile
TOP = tb_vcore_profiler

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- tb_vcore_profiler.sv
// testbench for the core profiler, random core activity checked against a reference model
// counters are read back over APB after each phase of stimulus
module tb_vcore_profiler;

  localparam int MODE_MIX       = 0;
  localparam int MODE_BRANCH    = 1;
  localparam int MODE_LOAD      = 2;
  localparam int MODE_STALL     = 3;
  localparam int PHASE_LEN      = 500;
  localparam int TIMEOUT_CYCLES = 4 * PHASE_LEN + 4 * 18 * 3 + 300;
  localparam int DMEM_AW        = 10;

  logic                           clk_i;
  logic                           reset_i;
  vcore_profiler_pkg::exe_event_s exe_d;
  vcore_profiler_pkg::id_info_s   id_d;
  vcore_profiler_pkg::sb_clear_s  clr_d;
  vcore_profiler_pkg::stall_vec_s stall_d;
  vcore_profiler_pkg::apb_req_s   apb_req;
  vcore_profiler_pkg::apb_rsp_s   apb_rsp;

  logic [31:0] exp_cnt [vcore_profiler_pkg::NUM_STATS];
  logic [31:0] sb_loc; // model scoreboard, one bit per register
  logic [31:0] sb_rem;
  int          checks      = 0;
  int          errors      = 0;
  int          cycle_count = 0;

  vcore_profiler i_vcore_profiler (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .exe_i  (exe_d),
    .id_i   (id_d),
    .clear_i(clr_d),
    .stall_i(stall_d),
    .apb_i  (apb_req),
    .apb_o  (apb_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic int unsigned rnd(input int unsigned n);
    return $urandom % n;
  endfunction

  // local dmem window for a 10-bit word address
  function automatic logic addr_is_local(input logic [31:0] addr);
    return addr[DMEM_AW+2] && (addr[31:DMEM_AW+3] == '0);
  endfunction

  function automatic logic [31:0] pick_addr();
    case (rnd(3))
      0: return {19'd0, 1'b1, 12'(rnd(4096))};
      1: return $urandom | 32'h8000_0000;
      default: return $urandom & 32'h0000_0fff; // below the window, so remote
    endcase
  endfunction

  function automatic logic [6:0] pick_opcode(input int mode);
    logic [6:0] ops [10];
    ops = '{vcore_profiler_pkg::OPC_OP, vcore_profiler_pkg::OPC_OP_IMM,
            vcore_profiler_pkg::OPC_LUI, vcore_profiler_pkg::OPC_AUIPC,
            vcore_profiler_pkg::OPC_LOAD, vcore_profiler_pkg::OPC_STORE,
            vcore_profiler_pkg::OPC_BRANCH, vcore_profiler_pkg::OPC_JAL,
            vcore_profiler_pkg::OPC_JALR, 7'b1110011}; // SYSTEM has no class
    if (mode == MODE_BRANCH && rnd(4) != 0) return ops[4'(6 + rnd(3))];
    if (mode == MODE_LOAD && rnd(2) != 0) return vcore_profiler_pkg::OPC_LOAD;
    return ops[4'(rnd(10))];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic drive_cycle(input int mode);
    logic [31:0]  w;
    logic [31:0]  iw;
    int unsigned  odds;
    w    = $urandom;
    iw   = $urandom;
    odds = (mode == MODE_STALL) ? 2 : 4;
    w[6:0] = pick_opcode(mode);
    if (rnd(2) == 0) w[31:25] = vcore_profiler_pkg::FUNCT7_MULDIV;
    iw[11:7]  = 5'(rnd(4)); // few registers, so hits and collisions are common
    iw[19:15] = 5'(rnd(4));
    iw[24:20] = 5'(rnd(4));
    @(posedge clk_i);
    exe_d.valid         <= rnd(10) < 8;
    exe_d.instr         <= w;
    exe_d.mispredict    <= rnd(2) == 0;
    exe_d.mem_addr      <= pick_addr();
    stall_d.stall       <= rnd(10) < 2;
    stall_d.depend      <= rnd(10) < ((mode == MODE_LOAD) ? 6 : 3);
    stall_d.ifetch_wait <= rnd(odds) == 0;
    stall_d.md          <= rnd(odds) == 0;
    stall_d.remote_req  <= rnd(odds) == 0;
    id_d.instr          <= iw;
    id_d.reads_rs1      <= rnd(2) == 0;
    id_d.reads_rs2      <= rnd(2) == 0;
    id_d.score_v        <= rnd(3) == 0;
    id_d.load_addr      <= pick_addr();
    clr_d.v             <= rnd(3) == 0;
    clr_d.remote        <= rnd(2) == 0;
    clr_d.rd            <= 5'(rnd(4));
  endtask

  task automatic run_phase(input int n, input int mode);
    repeat (n) drive_cycle(mode);
    @(posedge clk_i);
    exe_d   <= '0; // core idle during readout
    id_d    <= '0;
    clr_d   <= '0;
    stall_d <= '0;
  endtask

  task automatic apb_xfer(input logic wr, input logic [11:0] addr);
    logic [31:0] exp_data;
    logic        exp_err;
    @(posedge clk_i);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= $urandom;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    @(negedge clk_i);
    if (wr) begin
      exp_err  = (addr != vcore_profiler_pkg::CLEAR_ADDR);
      exp_data = '0;
    end else begin
      exp_err  = (addr[11:2] >= 10'd18);
      exp_data = exp_err ? '0 : exp_cnt[addr[6:2]];
    end
    check_value("pready", 32'(apb_rsp.pready), 32'd1);
    check_value($sformatf("prdata @%h", addr), apb_rsp.prdata, exp_data);
    check_value($sformatf("pslverr @%h", addr), 32'(apb_rsp.pslverr), 32'(exp_err));
    @(posedge clk_i);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
  endtask

  task automatic read_all_counters();
    for (logic [4:0] k = 5'd0; k < 5'd18; k++) begin
      apb_xfer(1'b0, {5'd0, k, 2'b00});
    end
  endtask

  // reference model, sees the same sampled inputs as the DUT at each edge
  always @(posedge clk_i) begin : ref_model
    logic [31:0] ew;
    logic [31:0] iw;
    logic [17:0] ev;
    logic        hit_l;
    logic        hit_r;
    logic        dep;
    if (reset_i) begin
      exp_cnt = '{default: '0};
      sb_loc  = '0;
      sb_rem  = '0;
    end else begin
      ew    = exe_d.instr;
      iw    = id_d.instr;
      hit_l = (id_d.reads_rs1 && sb_loc[iw[19:15]]) || (id_d.reads_rs2 && sb_loc[iw[24:20]]);
      hit_r = (id_d.reads_rs1 && sb_rem[iw[19:15]]) || (id_d.reads_rs2 && sb_rem[iw[24:20]]);
      ev    = '0;
      ev[vcore_profiler_pkg::CYCLE] = 1'b1;
      if (exe_d.valid && !stall_d.stall) begin
        ev[vcore_profiler_pkg::INSTR] = 1'b1;
        case (ew[6:0])
          vcore_profiler_pkg::OPC_OP: begin
            ev[vcore_profiler_pkg::MULDIV] = (ew[31:25] == vcore_profiler_pkg::FUNCT7_MULDIV);
            ev[vcore_profiler_pkg::ALU]    = (ew[31:25] != vcore_profiler_pkg::FUNCT7_MULDIV);
          end
          vcore_profiler_pkg::OPC_OP_IMM,
          vcore_profiler_pkg::OPC_LUI,
          vcore_profiler_pkg::OPC_AUIPC: ev[vcore_profiler_pkg::ALU] = 1'b1;
          vcore_profiler_pkg::OPC_LOAD: begin
            ev[vcore_profiler_pkg::LOAD_LOCAL]  = addr_is_local(exe_d.mem_addr);
            ev[vcore_profiler_pkg::LOAD_REMOTE] = !addr_is_local(exe_d.mem_addr);
          end
          vcore_profiler_pkg::OPC_STORE: ev[vcore_profiler_pkg::STORE] = 1'b1;
          vcore_profiler_pkg::OPC_BRANCH: begin
            ev[vcore_profiler_pkg::BRANCH]      = 1'b1;
            ev[vcore_profiler_pkg::BRANCH_MISS] = exe_d.mispredict;
          end
          vcore_profiler_pkg::OPC_JAL: ev[vcore_profiler_pkg::JAL] = 1'b1;
          vcore_profiler_pkg::OPC_JALR: begin
            ev[vcore_profiler_pkg::JALR]      = 1'b1;
            ev[vcore_profiler_pkg::JALR_MISS] = exe_d.mispredict;
          end
          default: ;
        endcase
      end
      dep = stall_d.depend && !stall_d.stall;
      ev[vcore_profiler_pkg::STALL_DEPEND]        = dep;
      ev[vcore_profiler_pkg::STALL_DEPEND_LOCAL]  = dep && hit_l;
      ev[vcore_profiler_pkg::STALL_DEPEND_REMOTE] = dep && hit_r;
      ev[vcore_profiler_pkg::STALL_IFETCH]        = stall_d.ifetch_wait;
      ev[vcore_profiler_pkg::STALL_MD]            = stall_d.md;
      ev[vcore_profiler_pkg::STALL_REMOTE_REQ]    = stall_d.remote_req;
      if (clr_d.v && clr_d.remote) sb_rem[clr_d.rd] = 1'b0;
      if (clr_d.v && !clr_d.remote) sb_loc[clr_d.rd] = 1'b0;
      if (id_d.score_v && addr_is_local(id_d.load_addr)) sb_loc[iw[11:7]] = 1'b1; // after clear
      if (id_d.score_v && !addr_is_local(id_d.load_addr)) sb_rem[iw[11:7]] = 1'b1;
      if (apb_req.psel && apb_req.penable && apb_req.pwrite &&
          apb_req.paddr == vcore_profiler_pkg::CLEAR_ADDR) begin
        exp_cnt = '{default: '0};
      end else begin
        for (logic [4:0] k = 5'd0; k < 5'd18; k++) begin
          exp_cnt[k] = exp_cnt[k] + 32'(ev[k]);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(39));
    reset_i = 1'b1;
    exe_d   = '0;
    id_d    = '0;
    clr_d   = '0;
    stall_d = '0;
    apb_req = '0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    run_phase(PHASE_LEN, MODE_MIX);
    read_all_counters();
    run_phase(PHASE_LEN, MODE_BRANCH);
    read_all_counters();
    apb_xfer(1'b1, vcore_profiler_pkg::CLEAR_ADDR);
    apb_xfer(1'b0, 12'h004); // instr count right after clear
    run_phase(PHASE_LEN, MODE_LOAD);
    read_all_counters();
    apb_xfer(1'b0, 12'h048); // slot 18 does not exist
    apb_xfer(1'b1, 12'h008); // writes to counter slots are refused
    run_phase(PHASE_LEN, MODE_STALL);
    apb_xfer(1'b1, 12'h104);
    read_all_counters();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- tb_vcore_profiler_assert.sv
// APB protocol and event consistency checks, bound into the profiler top
// sees the port signals and the event vector that feeds the counter bank
module tb_vcore_profiler_assert (
  input logic                            clk_i,
  input logic                            reset_i,
  input vcore_profiler_pkg::apb_req_s    apb_req_i,
  input vcore_profiler_pkg::apb_rsp_s    apb_rsp_i,
  input vcore_profiler_pkg::stat_event_s event_i
);

  logic access;
  logic bad_access;

  assign access     = apb_req_i.psel & apb_req_i.penable;
  assign bad_access = apb_req_i.pwrite ? (apb_req_i.paddr != vcore_profiler_pkg::CLEAR_ADDR)
                                       : (apb_req_i.paddr[11:2] >= 10'd18);

  pready_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
    access |-> apb_rsp_i.pready)
    else $error("pready low during an access phase");

  pslverr_only_bad: assert property (@(posedge clk_i) disable iff (reset_i)
    apb_rsp_i.pslverr |-> (access && bad_access))
    else $error("pslverr raised on a valid access");

  // split dependency events need the parent event
  depend_split: assert property (@(posedge clk_i) disable iff (reset_i)
    (event_i.stall_depend_local || event_i.stall_depend_remote) |-> event_i.stall_depend)
    else $error("dependency split event without a dependency stall");

endmodule

bind vcore_profiler tb_vcore_profiler_assert i_profiler_assert (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .apb_req_i(apb_i),
  .apb_rsp_i(apb_o),
  .event_i  (stat_event)
);

//--- vcore_profiler.sv
// profiler top for one core, counts execute-stage events and stalls
// counters are read and cleared over APB
module vcore_profiler #(
  parameter int CTR_WIDTH_P       = 32, // 16 to 32
  parameter int DMEM_ADDR_WIDTH_P = 10
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  vcore_profiler_pkg::exe_event_s exe_i,
  input  vcore_profiler_pkg::id_info_s   id_i,
  input  vcore_profiler_pkg::sb_clear_s  clear_i,
  input  vcore_profiler_pkg::stall_vec_s stall_i,
  input  vcore_profiler_pkg::apb_req_s   apb_i,
  output vcore_profiler_pkg::apb_rsp_s   apb_o
);

  logic                            dep_local;
  logic                            dep_remote;
  vcore_profiler_pkg::stat_event_s stat_event;
  logic                            ctr_clear;
  vcore_profiler_pkg::stat_idx_e   rd_idx;
  logic [CTR_WIDTH_P-1:0]          rd_data;

  event_decoder #(
    .DMEM_ADDR_WIDTH_P(DMEM_ADDR_WIDTH_P)
  ) i_event_decoder (
    .exe_i       (exe_i),
    .stall_i     (stall_i),
    .dep_local_i (dep_local),
    .dep_remote_i(dep_remote),
    .event_o     (stat_event)
  );

  load_scoreboard #(
    .DMEM_ADDR_WIDTH_P(DMEM_ADDR_WIDTH_P)
  ) i_load_scoreboard (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .id_i        (id_i),
    .clear_i     (clear_i),
    .dep_local_o (dep_local),
    .dep_remote_o(dep_remote)
  );

  stat_counter_bank #(
    .CTR_WIDTH_P(CTR_WIDTH_P)
  ) i_stat_counter_bank (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .event_i  (stat_event),
    .clear_i  (ctr_clear),
    .rd_idx_i (rd_idx),
    .rd_data_o(rd_data)
  );

  apb_stat_port #(
    .CTR_WIDTH_P(CTR_WIDTH_P)
  ) i_apb_stat_port (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .apb_i    (apb_i),
    .apb_o    (apb_o),
    .clear_o  (ctr_clear),
    .rd_idx_o (rd_idx),
    .rd_data_i(rd_data)
  );

endmodule

//--- apb_stat_port.sv
// APB slave for the profiler, reads counters by word index and takes the clear command
// no wait states, pready and pslverr are set up during the setup phase
module apb_stat_port #(
  parameter int CTR_WIDTH_P = 32
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  vcore_profiler_pkg::apb_req_s  apb_i,
  output vcore_profiler_pkg::apb_rsp_s  apb_o,
  output logic                          clear_o,
  output vcore_profiler_pkg::stat_idx_e rd_idx_o,
  input  logic [CTR_WIDTH_P-1:0]        rd_data_i
);

  localparam int AW = vcore_profiler_pkg::APB_ADDR_WIDTH;
  localparam int DW = vcore_profiler_pkg::APB_DATA_WIDTH;

  logic          setup;
  logic          access;
  logic [AW-3:0] word_idx;
  logic          idx_ok;
  logic          is_clear;
  logic          bad;
  logic          pready_r;
  logic          pslverr_r;

  assign setup  = apb_i.psel & ~apb_i.penable;
  assign access = apb_i.psel & apb_i.penable;

  assign word_idx = apb_i.paddr[AW-1:2];
  assign idx_ok   = (int'(word_idx) < vcore_profiler_pkg::NUM_STATS);
  assign is_clear = (apb_i.paddr == vcore_profiler_pkg::CLEAR_ADDR);
  assign bad      = apb_i.pwrite ? ~is_clear : ~idx_ok;

  // paddr is stable from setup into access, so decode early
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pready_r  <= 1'b0;
      pslverr_r <= 1'b0;
    end else begin
      pready_r  <= setup;
      pslverr_r <= setup & bad;
    end
  end

  assign rd_idx_o = vcore_profiler_pkg::stat_idx_e'(word_idx[4:0]);
  assign clear_o  = access & apb_i.pwrite & is_clear; // bank zeroes at end of access

  assign apb_o.prdata  = (access & ~apb_i.pwrite & idx_ok) ? DW'(rd_data_i) : '0;
  assign apb_o.pready  = pready_r;
  assign apb_o.pslverr = pslverr_r;

endmodule

//--- stat_counter_bank.sv
// bank of event counters, one per stat slot, read out by index
// clear zeroes the whole bank and wins over same-cycle increments
module stat_counter_bank #(
  parameter int CTR_WIDTH_P = 32
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  vcore_profiler_pkg::stat_event_s event_i,
  input  logic                            clear_i,
  input  vcore_profiler_pkg::stat_idx_e   rd_idx_i,
  output logic [CTR_WIDTH_P-1:0]          rd_data_o
);

  localparam int N = vcore_profiler_pkg::NUM_STATS;

  logic [N-1:0]                  inc;
  logic [N-1:0][CTR_WIDTH_P-1:0] ctr_r;

  assign inc = event_i; // bit i is slot i

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      ctr_r <= '0;
    end else begin
      for (int i = 0; i < N; i++) begin
        if (inc[i]) begin
          ctr_r[i] <= ctr_r[i] + CTR_WIDTH_P'(1); // wraps at full width
        end
      end
    end
  end

  // slots past the last counter read as zero
  assign rd_data_o = (int'(rd_idx_i) < N) ? ctr_r[rd_idx_i] : '0;

endmodule

//--- load_scoreboard.sv
// per-register record of outstanding local and remote loads
// reports whether the decode-stage operands wait on either kind
module load_scoreboard #(
  parameter int DMEM_ADDR_WIDTH_P = 10
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  vcore_profiler_pkg::id_info_s  id_i,
  input  vcore_profiler_pkg::sb_clear_s clear_i,
  output logic                          dep_local_o,
  output logic                          dep_remote_o
);

  localparam int NUM_REGS = 2 ** vcore_profiler_pkg::REG_ADDR_WIDTH;

  // bit 1 remote, bit 0 local
  logic [NUM_REGS-1:0][1:0] sb_r;

  logic [vcore_profiler_pkg::REG_ADDR_WIDTH-1:0] score_rd;
  logic [vcore_profiler_pkg::REG_ADDR_WIDTH-1:0] rs1;
  logic [vcore_profiler_pkg::REG_ADDR_WIDTH-1:0] rs2;
  logic                                          score_remote;
  logic [1:0]                                    rs1_bits;
  logic [1:0]                                    rs2_bits;

  assign score_rd = id_i.instr.i_view.rd;
  assign rs1      = id_i.instr.r_view.rs1;
  assign rs2      = id_i.instr.r_view.rs2;

  assign score_remote = ~vcore_profiler_pkg::is_local_addr(id_i.load_addr, DMEM_ADDR_WIDTH_P);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sb_r <= '0;
    end else begin
      if (clear_i.v) begin
        sb_r[clear_i.rd][clear_i.remote] <= 1'b0;
      end
      // later assignment, so a score overrides a clear of the same bit
      if (id_i.score_v) begin
        sb_r[score_rd][score_remote] <= 1'b1;
      end
    end
  end

  // lookup sees the state before this cycle's update
  assign rs1_bits = id_i.reads_rs1 ? sb_r[rs1] : 2'b00;
  assign rs2_bits = id_i.reads_rs2 ? sb_r[rs2] : 2'b00;

  assign dep_local_o  = rs1_bits[0] | rs2_bits[0];
  assign dep_remote_o = rs1_bits[1] | rs2_bits[1];

endmodule

//--- event_decoder.sv
// turns the execute-stage instruction and the stall lines into one event bit per counter
// purely combinational, feeds the counter bank directly
module event_decoder #(
  parameter int DMEM_ADDR_WIDTH_P = 10
) (
  input  vcore_profiler_pkg::exe_event_s  exe_i,
  input  vcore_profiler_pkg::stall_vec_s  stall_i,
  input  logic                            dep_local_i,
  input  logic                            dep_remote_i,
  output vcore_profiler_pkg::stat_event_s event_o
);

  logic       retire;
  logic [6:0] opcode;
  logic [6:0] funct7;
  logic       load_is_local;
  logic       depend_inc;

  assign retire = exe_i.valid & ~stall_i.stall;
  assign opcode = exe_i.instr.i_view.opcode;
  assign funct7 = exe_i.instr.r_view.funct7; // only meaningful for OP
  assign load_is_local = vcore_profiler_pkg::is_local_addr(exe_i.mem_addr, DMEM_ADDR_WIDTH_P);

  // a dependency stall only counts when nothing else holds the pipe
  assign depend_inc = stall_i.depend & ~stall_i.stall;

  always_comb begin
    event_o = '0;
    event_o.cycle = 1'b1;
    event_o.instr = retire;

    if (retire) begin
      case (opcode)
        vcore_profiler_pkg::OPC_OP: begin
          if (funct7 == vcore_profiler_pkg::FUNCT7_MULDIV) begin
            event_o.muldiv = 1'b1;
          end else begin
            event_o.alu = 1'b1;
          end
        end
        vcore_profiler_pkg::OPC_OP_IMM,
        vcore_profiler_pkg::OPC_LUI,
        vcore_profiler_pkg::OPC_AUIPC: event_o.alu = 1'b1;
        vcore_profiler_pkg::OPC_LOAD: begin
          event_o.load_local  = load_is_local;
          event_o.load_remote = ~load_is_local;
        end
        vcore_profiler_pkg::OPC_STORE: event_o.store = 1'b1;
        vcore_profiler_pkg::OPC_BRANCH: begin
          event_o.branch      = 1'b1;
          event_o.branch_miss = exe_i.mispredict;
        end
        vcore_profiler_pkg::OPC_JAL: event_o.jal = 1'b1; // never a miss
        vcore_profiler_pkg::OPC_JALR: begin
          event_o.jalr      = 1'b1;
          event_o.jalr_miss = exe_i.mispredict;
        end
        default: ; // other opcodes only bump instr
      endcase
    end

    // both halves may fire in one cycle
    event_o.stall_depend        = depend_inc;
    event_o.stall_depend_local  = depend_inc & dep_local_i;
    event_o.stall_depend_remote = depend_inc & dep_remote_i;

    event_o.stall_ifetch     = stall_i.ifetch_wait;
    event_o.stall_md         = stall_i.md;
    event_o.stall_remote_req = stall_i.remote_req;
  end

endmodule

//--- vcore_profiler_pkg.sv
// constants, counter indices and bus types shared by the core profiler blocks
// other files refer to these by scoped name
package vcore_profiler_pkg;

  localparam int NUM_STATS      = 18;
  localparam int APB_ADDR_WIDTH = 12;
  localparam int APB_DATA_WIDTH = 32;
  localparam int REG_ADDR_WIDTH = 5;

  localparam logic [APB_ADDR_WIDTH-1:0] CLEAR_ADDR = 12'h100; // write here zeroes the bank

  // counter slots, word index on the apb port
  typedef enum logic [4:0] {
    CYCLE,
    INSTR,
    ALU,
    MULDIV,
    LOAD_LOCAL,
    LOAD_REMOTE,
    STORE,
    BRANCH,
    BRANCH_MISS,
    JAL,
    JALR,
    JALR_MISS,
    STALL_DEPEND,
    STALL_DEPEND_LOCAL,
    STALL_DEPEND_REMOTE,
    STALL_IFETCH,
    STALL_MD,
    STALL_REMOTE_REQ
  } stat_idx_e;

  // rv32 base opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // M extension on OP

  typedef struct packed {
    logic [6:0]                funct7;
    logic [REG_ADDR_WIDTH-1:0] rs2;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [2:0]                funct3;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [6:0]                opcode;
  } rv32_r_view_s;

  typedef struct packed {
    logic [11:0]               imm12;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [2:0]                funct3;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [6:0]                opcode;
  } rv32_i_view_s;

  typedef union packed {
    rv32_r_view_s r_view;
    rv32_i_view_s i_view;
  } rv32_instr_u;

  typedef struct packed {
    logic        valid;
    rv32_instr_u instr;
    logic        mispredict; // branch or jalr, whichever is in exe
    logic [31:0] mem_addr;   // computed load/store address
  } exe_event_s;

  typedef struct packed {
    rv32_instr_u instr;
    logic        reads_rs1;
    logic        reads_rs2;
    logic        score_v;
    logic [31:0] load_addr;
  } id_info_s;

  typedef struct packed {
    logic                      v;
    logic                      remote;
    logic [REG_ADDR_WIDTH-1:0] rd;
  } sb_clear_s;

  typedef struct packed {
    logic stall; // global pipeline stall
    logic depend;
    logic ifetch_wait;
    logic md;
    logic remote_req;
  } stall_vec_s;

  // declared high to low so that bit i is counter slot i
  typedef struct packed {
    logic stall_remote_req;
    logic stall_md;
    logic stall_ifetch;
    logic stall_depend_remote;
    logic stall_depend_local;
    logic stall_depend;
    logic jalr_miss;
    logic jalr;
    logic jal;
    logic branch_miss;
    logic branch;
    logic store;
    logic load_remote;
    logic load_local;
    logic muldiv;
    logic alu;
    logic instr;
    logic cycle;
  } stat_event_s;

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_s;

  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_s;

  // local dmem sits at the window selected by bit 2+width, nothing set above it
  function automatic logic is_local_addr(input logic [31:0] addr,
                                         input int unsigned dmem_addr_width);
    return addr[2+dmem_addr_width] & ((addr >> (3 + dmem_addr_width)) == 32'd0);
  endfunction

endpackage
